// ==== Bender.yml ====
package:
  name: fe_frontend

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fe_pkg.sv
      - hdl/fe_control.sv
      - hdl/fe_pc_gen.sv
      - hdl/fe_fetch_pipe.sv
      - hdl/fe_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/fe_clock_gen.sv
      - dv/fe_top_tb.sv

// ==== all.f ====
+incdir+hdl
hdl/fe_pkg.sv
hdl/fe_control.sv
hdl/fe_pc_gen.sv
hdl/fe_fetch_pipe.sv
hdl/fe_top.sv
dv/fe_clock_gen.sv
dv/fe_top_tb.sv

// ==== dv/fe_clock_gen.sv ====
`default_nettype none

module fe_clock_gen
  (
  output logic clk_o,
  output logic reset_o
  );

  // Period of 40, reset held over the first 4 rising edges
  initial
  begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

  always #20 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== dv/fe_top_tb.sv ====
`include "fe_defines.svh"

`default_nettype none

module fe_top_tb;

  import fe_pkg::*;

  logic                       clk_i;
  logic                       reset_i;
  logic                       fe_cmd_v_i = 1'b0;
  fe_opcode_e                 fe_cmd_opcode_i = e_op_wait;
  logic [`FE_VADDR_WIDTH-1:0] fe_cmd_pc_i = '0;
  logic                       imem_v_o;
  logic [`FE_VADDR_WIDTH-1:0] imem_addr_o;
  logic [`FE_INSTR_WIDTH-1:0] imem_data_i = '0;
  logic                       fe_queue_v_o;
  fe_msg_type_e               fe_queue_type_o;
  logic [`FE_VADDR_WIDTH-1:0] fe_queue_pc_o;
  logic [`FE_INSTR_WIDTH-1:0] fe_queue_instr_o;
  logic                       fe_queue_ready_i = 1'b0;

  integer seed = 32'hd9ca;
  string  test_name = "reset_idle";
  logic   random_ready = 1'b0;
  logic   cmd_seen = 1'b0;
  logic   model_en = 1'b0;
  int     transfer_count = 0;
  int     exception_count = 0;

  logic [`FE_VADDR_WIDTH-1:0] exp_pc = '0;
  logic [`FE_VADDR_WIDTH-1:0] fetch_addr_q = '0;

  fe_clock_gen clock_gen
    (
    .clk_o   (clk_i),
    .reset_o (reset_i)
    );

  fe_top fe_top_i (.*);

  function automatic logic [`FE_INSTR_WIDTH-1:0] mem_hash(input logic [`FE_VADDR_WIDTH-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  // Instruction memory with one cycle of latency
  always @(posedge clk_i)
  begin
    if (imem_v_o)
    begin
      fetch_addr_q <= imem_addr_o;
    end
  end

  always @(negedge clk_i)
  begin
    imem_data_i = mem_hash(fetch_addr_q);
  end

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected)
    else
    begin
      $display("Fail %s %s: expected %h actual %h", test_name, field, expected, actual);
      stop_on_error();
    end
  endtask

  // Reference model of the transferred stream
  task automatic check_transfer();
    logic is_fault;
    is_fault = (exp_pc >= `FE_PC_LIMIT);
    assert (model_en)
    else
    begin
      $display("%s: message at pc %h while the queue should be quiet", test_name, fe_queue_pc_o);
      stop_on_error();
    end
    check_value("pc", exp_pc, fe_queue_pc_o);
    check_value("type", is_fault ? e_fe_exception : e_fe_fetch, fe_queue_type_o);
    check_value("instr", is_fault ? '0 : mem_hash(exp_pc), fe_queue_instr_o);
    transfer_count++;
    exp_pc = exp_pc + `FE_PC_STEP;
    if (is_fault)
    begin
      model_en = 1'b0;
      exception_count++;
    end
  endtask

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      assert (fe_queue_ready_i || !fe_queue_v_o)
      else
      begin
        $display("%s: queue valid is high while ready is low", test_name);
        stop_on_error();
      end
      if (!cmd_seen && !fe_cmd_v_i)
      begin
        assert (!fe_queue_v_o && !imem_v_o)
        else
        begin
          $display("%s: front end became active before any command", test_name);
          stop_on_error();
        end
      end
      if (fe_queue_v_o)
      begin
        check_transfer();
      end
      if (fe_cmd_v_i)
      begin
        cmd_seen = 1'b1;
        model_en = (fe_cmd_opcode_i != e_op_wait);
        exp_pc   = fe_cmd_pc_i;
      end
    end
  end

  task automatic step_cycle();
    @(negedge clk_i);
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
  endtask

  task automatic drive_cmd(input fe_opcode_e op, input logic [`FE_VADDR_WIDTH-1:0] pc);
    fe_cmd_v_i      = 1'b1;
    fe_cmd_opcode_i = op;
    fe_cmd_pc_i     = pc;
  endtask

  task automatic issue_cmd(input fe_opcode_e op, input logic [`FE_VADDR_WIDTH-1:0] pc);
    step_cycle();
    drive_cmd(op, pc);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (reset_i)
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20)
      begin
        $display("Reset was never released");
        stop_on_error();
      end
    end
  endtask

  task automatic wait_messages(input int transfers, input int exceptions, input int limit);
    int transfer_target;
    int exception_target;
    int cycles;
    transfer_target  = transfer_count + transfers;
    exception_target = exception_count + exceptions;
    cycles = 0;
    while (transfer_count < transfer_target || exception_count < exception_target)
    begin
      step_cycle();
      cycles++;
      if (cycles > limit)
      begin
        $display("Timeout in %s while waiting for queue messages", test_name);
        stop_on_error();
      end
    end
  endtask

  // Half the PCs land around the fault limit
  function automatic logic [`FE_VADDR_WIDTH-1:0] random_pc();
    logic [`FE_VADDR_WIDTH-1:0] offset;
    offset = ($random(seed) & 32'h1f) << 2;
    if ($random(seed) & 1)
    begin
      return `FE_PC_LIMIT - 64 + offset;
    end
    return ($random(seed) & 32'hfff) << 2;
  endfunction

  task automatic random_mix(input int cycles);
    int kind;
    for (int n = 0; n < cycles; n++)
    begin
      step_cycle();
      if (($random(seed) & 31) == 0)
      begin
        kind = $random(seed) & 7;
        if (kind < 5)
        begin
          drive_cmd(e_op_pc_redirect, random_pc());
        end
        else if (kind < 7)
        begin
          drive_cmd(e_op_state_reset, random_pc());
        end
        else
        begin
          drive_cmd(e_op_wait, '0);
        end
      end
    end
  endtask

  initial
  begin
    wait_for_reset();
    run_cycles(10);
    test_name = "sequential";
    issue_cmd(e_op_pc_redirect, 32'h0000_0100);
    wait_messages(40, 0, 200);
    test_name = "wait_cmd";
    issue_cmd(e_op_wait, '0);
    run_cycles(20);
    test_name = "backpressure";
    random_ready = 1'b1;
    issue_cmd(e_op_pc_redirect, 32'h0000_2000);
    wait_messages(100, 0, 2000);
    test_name = "redirect";
    issue_cmd(e_op_pc_redirect, 32'h0000_0800);
    wait_messages(20, 0, 500);
    issue_cmd(e_op_state_reset, 32'h0000_1200);
    wait_messages(20, 0, 500);
    test_name = "access_fault";
    issue_cmd(e_op_pc_redirect, `FE_PC_LIMIT - 32);
    wait_messages(0, 1, 500);
    run_cycles(20);
    issue_cmd(e_op_pc_redirect, `FE_PC_LIMIT + 8);
    wait_messages(0, 1, 100);
    run_cycles(20);
    test_name = "random_mix";
    random_mix(3000);
    issue_cmd(e_op_wait, '0);
    run_cycles(10);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/fe_control.sv ====
`include "fe_defines.svh"

`default_nettype none

module fe_control
  (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       fe_cmd_v_i,
  input  fe_pkg::fe_opcode_e         fe_cmd_opcode_i,
  input  logic [`FE_VADDR_WIDTH-1:0] fe_cmd_pc_i,

  input  logic [`FE_VADDR_WIDTH-1:0] if2_pc_i,
  input  logic                       fetch_fail_v_i,
  input  logic                       exception_v_i,
  input  logic                       fe_queue_ready_i,

  output logic                       redirect_v_o,
  output logic                       next_fetch_v_o,
  output logic                       cmd_flush_v_o,
  output logic [`FE_VADDR_WIDTH-1:0] redirect_pc_o
  );

  import fe_pkg::*;

  fe_state_e state_r;
  fe_state_e state_n;

  logic is_run;
  logic is_stall;

  logic state_reset_v;
  logic pc_redirect_v;
  logic wait_v;
  logic cmd_immediate_v;
  logic cmd_complex_v;

  logic                       resume_en;
  logic [`FE_VADDR_WIDTH-1:0] pc_resume_n;
  logic [`FE_VADDR_WIDTH-1:0] pc_resume_r;

  assign is_run   = (state_r == e_run);
  assign is_stall = (state_r == e_stall);

  // Command decode
  assign state_reset_v = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_state_reset);
  assign pc_redirect_v = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_pc_redirect);
  assign wait_v        = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_wait);

  assign cmd_immediate_v = pc_redirect_v;
  assign cmd_complex_v   = state_reset_v;

  // Any command flushes whatever is in flight
  assign cmd_flush_v_o = fe_cmd_v_i;

  // Resume PC follows IF2 while running, a command overrides it
  assign resume_en   = fe_cmd_v_i | is_run;
  assign pc_resume_n = fe_cmd_v_i ? fe_cmd_pc_i : if2_pc_i;

  always_ff @(posedge clk_i)
  begin
    if (resume_en)
    begin
      pc_resume_r <= pc_resume_n;
    end
  end

  assign redirect_pc_o = resume_en ? pc_resume_n : pc_resume_r;

  always_comb
  begin
    state_n = state_r;
    if (cmd_immediate_v)
    begin
      state_n = e_run;
    end
    else if (cmd_complex_v)
    begin
      state_n = e_stall;
    end
    else if (wait_v)
    begin
      state_n = e_wait;
    end
    else
    begin
      case (state_r)
        e_wait:  state_n = e_wait;
        // Replay once the queue can take the message again
        e_stall: state_n = fe_queue_ready_i ? e_run : e_stall;
        e_run:
        begin
          if (fetch_fail_v_i)
          begin
            state_n = e_stall;
          end
          else if (exception_v_i)
          begin
            state_n = e_wait;
          end
        end
        default: state_n = e_wait;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_wait;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  assign next_fetch_v_o = (state_n == e_run);
  assign redirect_v_o   = cmd_immediate_v | (is_stall & next_fetch_v_o);

  state_legal_a: assert property (@(posedge clk_i) disable iff (reset_i)
    state_r inside {e_wait, e_run, e_stall});

endmodule

`default_nettype wire

// ==== hdl/fe_defines.svh ====
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// Virtual PC and instruction widths
`define FE_VADDR_WIDTH 32
`define FE_INSTR_WIDTH 32

// Byte distance between sequential fetches
`define FE_PC_STEP 4

// Fetches at or above this PC raise an access fault
`define FE_PC_LIMIT 32'h0000_4000

`endif

// ==== hdl/fe_fetch_pipe.sv ====
`include "fe_defines.svh"

`default_nettype none

module fe_fetch_pipe
  (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       next_fetch_v_i,
  input  logic [`FE_VADDR_WIDTH-1:0] next_fetch_pc_i,
  input  logic                       cmd_flush_v_i,
  input  logic [`FE_INSTR_WIDTH-1:0] imem_data_i,
  input  logic [`FE_VADDR_WIDTH-1:0] if2_pc_i,
  input  logic                       fe_queue_ready_i,

  output logic                       fetch_fail_v_o,
  output logic                       exception_v_o,

  output logic                       fe_queue_v_o,
  output fe_pkg::fe_msg_type_e       fe_queue_type_o,
  output logic [`FE_VADDR_WIDTH-1:0] fe_queue_pc_o,
  output logic [`FE_INSTR_WIDTH-1:0] fe_queue_instr_o
  );

  import fe_pkg::*;

  logic v_if1_r;
  logic v_if2_r;
  logic v_if2_n;
  logic poison_if1;

  logic fault_if1_r;
  logic fault_if2_r;
  logic fe_exception_v;

  logic [`FE_INSTR_WIDTH-1:0] instr_if2_r;

  // IF1 is dropped on a failed fetch, a command, or a faulting IF2
  assign poison_if1 = fetch_fail_v_o | cmd_flush_v_i | fe_exception_v;
  assign v_if2_n    = v_if1_r & ~poison_if1;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      v_if1_r <= next_fetch_v_i;
      v_if2_r <= v_if2_n;
    end
  end

  // Range check stands in for the access fault path
  always_ff @(posedge clk_i)
  begin
    fault_if1_r <= (next_fetch_pc_i >= `FE_PC_LIMIT);
    fault_if2_r <= fault_if1_r;
  end

  // Memory data arrives while the fetch sits in IF1
  always_ff @(posedge clk_i)
  begin
    if (v_if1_r)
    begin
      instr_if2_r <= imem_data_i;
    end
  end

  assign fe_exception_v = v_if2_r & fault_if2_r;

  // A command in the same cycle hides the IF2 message
  assign fe_queue_v_o   = fe_queue_ready_i & v_if2_r & ~cmd_flush_v_i;
  assign fetch_fail_v_o = v_if2_r & ~fe_queue_ready_i & ~cmd_flush_v_i;
  assign exception_v_o  = fe_queue_v_o & fault_if2_r;

  assign fe_queue_type_o  = fault_if2_r ? e_fe_exception : e_fe_fetch;
  assign fe_queue_pc_o    = if2_pc_i;
  assign fe_queue_instr_o = fault_if2_r ? '0 : instr_if2_r;

  // After a delivered exception the front end goes quiet
  exception_quiets_a: assert property (@(posedge clk_i) disable iff (reset_i)
    exception_v_o |=> !fe_queue_v_o);

endmodule

`default_nettype wire

// ==== hdl/fe_pc_gen.sv ====
`include "fe_defines.svh"

`default_nettype none

module fe_pc_gen
  (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       redirect_v_i,
  input  logic                       next_fetch_v_i,
  input  logic [`FE_VADDR_WIDTH-1:0] redirect_pc_i,

  output logic [`FE_VADDR_WIDTH-1:0] next_fetch_pc_o,
  output logic [`FE_VADDR_WIDTH-1:0] if2_pc_o
  );

  logic [`FE_VADDR_WIDTH-1:0] last_pc_r;
  logic [`FE_VADDR_WIDTH-1:0] if1_pc_r;
  logic [`FE_VADDR_WIDTH-1:0] if2_pc_r;

  assign next_fetch_pc_o = redirect_v_i ? redirect_pc_i : last_pc_r + `FE_PC_STEP;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      last_pc_r <= '0;
    end
    else if (next_fetch_v_i)
    begin
      last_pc_r <= next_fetch_pc_o;
    end
  end

  // PC travels alongside the fetch, valids live in the fetch pipe
  always_ff @(posedge clk_i)
  begin
    if1_pc_r <= next_fetch_pc_o;
    if2_pc_r <= if1_pc_r;
  end

  assign if2_pc_o = if2_pc_r;

  fetch_pc_aligned_a: assert property (@(posedge clk_i) disable iff (reset_i)
    next_fetch_v_i |-> (next_fetch_pc_o % `FE_PC_STEP) == 0);

endmodule

`default_nettype wire

// ==== hdl/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

  // Commands from the back end
  typedef enum logic [1:0] {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_wait        = 2'd2
  } fe_opcode_e;

  // Front end control FSM
  typedef enum logic [1:0] {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  // Queue message kind
  typedef enum logic {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

endpackage

`default_nettype wire

// ==== hdl/fe_top.sv ====
`include "fe_defines.svh"

`default_nettype none

module fe_top
  (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       fe_cmd_v_i,
  input  fe_pkg::fe_opcode_e         fe_cmd_opcode_i,
  input  logic [`FE_VADDR_WIDTH-1:0] fe_cmd_pc_i,

  output logic                       imem_v_o,
  output logic [`FE_VADDR_WIDTH-1:0] imem_addr_o,
  input  logic [`FE_INSTR_WIDTH-1:0] imem_data_i,

  output logic                       fe_queue_v_o,
  output fe_pkg::fe_msg_type_e       fe_queue_type_o,
  output logic [`FE_VADDR_WIDTH-1:0] fe_queue_pc_o,
  output logic [`FE_INSTR_WIDTH-1:0] fe_queue_instr_o,
  input  logic                       fe_queue_ready_i
  );

  logic                       redirect_v;
  logic [`FE_VADDR_WIDTH-1:0] redirect_pc;
  logic                       next_fetch_v;
  logic [`FE_VADDR_WIDTH-1:0] next_fetch_pc;
  logic [`FE_VADDR_WIDTH-1:0] if2_pc;
  logic                       fetch_fail_v;
  logic                       exception_v;
  logic                       cmd_flush_v;

  fe_control control
    (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_opcode_i  (fe_cmd_opcode_i),
    .fe_cmd_pc_i      (fe_cmd_pc_i),
    .if2_pc_i         (if2_pc),
    .fetch_fail_v_i   (fetch_fail_v),
    .exception_v_i    (exception_v),
    .fe_queue_ready_i (fe_queue_ready_i),
    .redirect_v_o     (redirect_v),
    .next_fetch_v_o   (next_fetch_v),
    .cmd_flush_v_o    (cmd_flush_v),
    .redirect_pc_o    (redirect_pc)
    );

  fe_pc_gen pc_gen
    (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .redirect_v_i    (redirect_v),
    .next_fetch_v_i  (next_fetch_v),
    .redirect_pc_i   (redirect_pc),
    .next_fetch_pc_o (next_fetch_pc),
    .if2_pc_o        (if2_pc)
    );

  fe_fetch_pipe fetch_pipe
    (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .next_fetch_v_i   (next_fetch_v),
    .next_fetch_pc_i  (next_fetch_pc),
    .cmd_flush_v_i    (cmd_flush_v),
    .imem_data_i      (imem_data_i),
    .if2_pc_i         (if2_pc),
    .fe_queue_ready_i (fe_queue_ready_i),
    .fetch_fail_v_o   (fetch_fail_v),
    .exception_v_o    (exception_v),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_type_o  (fe_queue_type_o),
    .fe_queue_pc_o    (fe_queue_pc_o),
    .fe_queue_instr_o (fe_queue_instr_o)
    );

  assign imem_v_o    = next_fetch_v;
  assign imem_addr_o = next_fetch_pc;

endmodule

`default_nettype wire
